//--- design/osd_bitmap_ram.sv
////////////////////////////////////////////////////////////
// Contents undefined until written, read data one cycle late
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module osd_bitmap_ram (
	input  logic                  clk_video,
	input  logic                  wr_en,
	input  osd_pkg::bitmap_addr_t wr_addr,
	input  osd_pkg::bitmap_byte_t wr_data,
	input  osd_pkg::bitmap_addr_t rd_addr,
	output osd_pkg::bitmap_byte_t rd_data
);

	osd_pkg::bitmap_byte_t mem [0:osd_pkg::bitmap_depth-1];

	always_ff @(posedge clk_video) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// Registered read port
	always_ff @(posedge clk_video) begin
		rd_data <= mem[rd_addr];
	end

endmodule

//--- design/osd_cmd_decoder.sv
////////////////////////////////////////////////////////////
// Words are taken on strobe rising edges while cmd_sel is high
// No back-pressure, strobe edges need two cycles of spacing
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module osd_cmd_decoder (
	input  logic                  clk_video,
	input  logic                  rst,
	input  logic                  cmd_sel,
	input  logic                  cmd_strobe,
	input  osd_pkg::cmd_word_t    cmd_din,
	output logic                  wr_en,
	output osd_pkg::bitmap_addr_t wr_addr,
	output osd_pkg::bitmap_byte_t wr_data,
	output logic                  osd_enable,
	output osd_pkg::amix_t        amix
);

	osd_pkg::dec_state_t state;
	logic                strobe_d;
	logic                word_take;
	logic                wr_word;
	logic [7:0]          cmd;
	logic [2:0]          word_cnt;
	logic                en_pending;

	assign word_take = cmd_sel & cmd_strobe & ~strobe_d;
	assign wr_word = word_take && (state == osd_pkg::have_cmd) &&
		(cmd == osd_pkg::cmd_write);

	always_ff @(posedge clk_video) begin
		if (rst) begin
			state <= osd_pkg::idle;
			strobe_d <= 1'b0;
			cmd <= 8'h00;
			word_cnt <= 3'd0;
			en_pending <= 1'b0;
			osd_enable <= 1'b0;
			amix <= 2'd0;
			wr_en <= 1'b0;
			wr_addr <= '0;
		end else begin
			strobe_d <= cmd_strobe;
			wr_en <= wr_word;

			// Advance after each byte lands, wraps at 2048
			if (wr_en) begin
				wr_addr <= wr_addr + 1'b1;
			end

			if (!cmd_sel) begin
				// Enable applies once the transaction closes
				if (state != osd_pkg::idle && cmd == osd_pkg::cmd_enable) begin
					osd_enable <= en_pending;
				end
				state <= osd_pkg::idle;
				word_cnt <= 3'd0;
			end else if (word_take) begin
				case (state)
					osd_pkg::idle: begin
						cmd <= cmd_din[7:0];
						word_cnt <= 3'd0;
						if (cmd_din[7:0] == osd_pkg::cmd_write) begin
							state <= osd_pkg::addr_param;
						end else begin
							state <= osd_pkg::have_cmd;
						end
					end
					osd_pkg::addr_param: begin
						if (word_cnt == osd_pkg::addr_param_index) begin
							wr_addr <= {cmd_din[2:0], 8'h00};
						end
						if (word_cnt == osd_pkg::write_param_count - 3'd1) begin
							state <= osd_pkg::have_cmd;
							word_cnt <= 3'd0;
						end else begin
							word_cnt <= word_cnt + 3'd1;
						end
					end
					osd_pkg::have_cmd: begin
						if (cmd == osd_pkg::cmd_enable && word_cnt == 3'd0) begin
							en_pending <= cmd_din[0];
						end
						if (cmd == osd_pkg::cmd_amix) begin
							amix <= cmd_din[1:0];
						end
						if (word_cnt != 3'd7) begin
							word_cnt <= word_cnt + 3'd1;
						end
					end
					default: begin
						state <= osd_pkg::idle;
					end
				endcase
			end
		end
	end

	// Byte goes out with wr_en
	always_ff @(posedge clk_video) begin
		if (wr_word) begin
			wr_data <= cmd_din[7:0];
		end
	end

endmodule

//--- design/osd_mixer.sv
////////////////////////////////////////////////////////////
// Two-cycle pixel path, rd_data must arrive one cycle after din
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module osd_mixer (
	input  logic                  clk_video,
	input  logic                  rst,
	input  osd_pkg::rgb_t         din,
	input  logic                  de_in,
	input  osd_pkg::bitmap_byte_t rd_data,
	input  logic [2:0]            row_bit,
	input  logic                  in_window,
	output osd_pkg::rgb_t         dout,
	output logic                  de_out
);

	osd_pkg::rgb_t din_q;
	osd_pkg::rgb_t osd_rgb;
	logic [2:0]    row_q;
	logic          win_q;
	logic          de_d;
	logic          osd_pixel;

	// OSD bit twice, tint bit, then the top of the video channel
	function automatic logic [7:0] blend_channel(input logic pix, input logic tint,
		input logic [7:0] chan);
		return {pix, pix, tint, chan[7:3]};
	endfunction

	assign osd_pixel = rd_data[row_q];
	assign osd_rgb = {
		blend_channel(osd_pixel, osd_pkg::osd_color[2], din_q[23:16]),
		blend_channel(osd_pixel, osd_pkg::osd_color[1], din_q[15:8]),
		blend_channel(osd_pixel, osd_pkg::osd_color[0], din_q[7:0])
	};

	always_ff @(posedge clk_video) begin
		din_q <= din;
		row_q <= row_bit;
	end

	always_ff @(posedge clk_video) begin
		if (rst) begin
			win_q <= 1'b0;
			de_d <= 1'b0;
			de_out <= 1'b0;
			dout <= '0;
		end else begin
			win_q <= in_window;
			de_d <= de_in;
			de_out <= de_d;
			dout <= win_q ? osd_rgb : din_q;
		end
	end

endmodule

//--- design/osd_overlay.sv
////////////////////////////////////////////////////////////
// OSD overlay on one clock, one pixel per clock, 2-cycle latency
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module osd_overlay (
	input  logic               clk_video,
	input  logic               rst,
	input  logic               cmd_sel,
	input  logic               cmd_strobe,
	input  osd_pkg::cmd_word_t cmd_din,
	input  osd_pkg::rgb_t      din,
	input  logic               de_in,
	output osd_pkg::rgb_t      dout,
	output logic               de_out,
	output osd_pkg::amix_t     amix
);

	logic                  wr_en;
	osd_pkg::bitmap_addr_t wr_addr;
	osd_pkg::bitmap_byte_t wr_data;
	logic                  osd_enable;
	osd_pkg::bitmap_addr_t rd_addr;
	osd_pkg::bitmap_byte_t rd_data;
	logic [2:0]            row_bit;
	logic                  in_window;

	osd_cmd_decoder i_cmd_decoder (
		.clk_video  (clk_video),
		.rst        (rst),
		.cmd_sel    (cmd_sel),
		.cmd_strobe (cmd_strobe),
		.cmd_din    (cmd_din),
		.wr_en      (wr_en),
		.wr_addr    (wr_addr),
		.wr_data    (wr_data),
		.osd_enable (osd_enable),
		.amix       (amix)
	);

	osd_bitmap_ram i_bitmap_ram (
		.clk_video (clk_video),
		.wr_en     (wr_en),
		.wr_addr   (wr_addr),
		.wr_data   (wr_data),
		.rd_addr   (rd_addr),
		.rd_data   (rd_data)
	);

	osd_raster_timer i_raster_timer (
		.clk_video  (clk_video),
		.rst        (rst),
		.de_in      (de_in),
		.osd_enable (osd_enable),
		.rd_addr    (rd_addr),
		.row_bit    (row_bit),
		.in_window  (in_window)
	);

	osd_mixer i_mixer (
		.clk_video (clk_video),
		.rst       (rst),
		.din       (din),
		.de_in     (de_in),
		.rd_data   (rd_data),
		.row_bit   (row_bit),
		.in_window (in_window),
		.dout      (dout),
		.de_out    (de_out)
	);

endmodule

//--- design/osd_pkg.sv
////////////////////////////////////////////////////////////
// Shared widths, window geometry, tint and command codes
// Offsets are signed trims applied after centring
////////////////////////////////////////////////////////////

package osd_pkg;

	// Pixel, red in bits 23:16
	typedef logic [23:0] rgb_t;

	typedef logic [15:0] cmd_word_t;

	// Row band in 10:8, column in 7:0
	typedef logic [10:0] bitmap_addr_t;

	// One bit per row within a band
	typedef logic [7:0] bitmap_byte_t;

	typedef logic [11:0] line_cnt_t;

	typedef logic [1:0] amix_t;

	typedef enum logic [1:0] {
		idle,
		have_cmd,
		addr_param
	} dec_state_t;

	localparam int bitmap_depth = 2048;

	// Window geometry
	localparam line_cnt_t osd_width = 12'd256;
	localparam line_cnt_t osd_height = 12'd64;

	// Tint bits, red to blue
	localparam logic [2:0] osd_color = 3'd4;

	localparam logic signed [11:0] osd_x_offset = 12'sd0;
	localparam logic signed [11:0] osd_y_offset = 12'sd0;

	// Command codes
	localparam logic [7:0] cmd_write = 8'h0C;
	localparam logic [7:0] cmd_enable = 8'h28;
	localparam logic [7:0] cmd_amix = 8'h74;

	// Write command parameters ahead of the data words
	localparam logic [2:0] write_param_count = 3'd4;
	localparam logic [2:0] addr_param_index = 3'd3;

endpackage

//--- design/osd_raster_timer.sv
////////////////////////////////////////////////////////////
// Timing comes from de_in only, frame start needs a gap over 4 widths
// Outputs are aligned to the pixel currently on de_in
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module osd_raster_timer (
	input  logic                  clk_video,
	input  logic                  rst,
	input  logic                  de_in,
	input  logic                  osd_enable,
	output osd_pkg::bitmap_addr_t rd_addr,
	output logic [2:0]            row_bit,
	output logic                  in_window
);

	logic                de_d;
	logic                de_rise;
	logic                de_fall;
	logic                frame_start;
	logic                active;
	logic                row_ok;
	logic [13:0]         gap_cnt;
	// Index of the pixel seen one cycle earlier
	osd_pkg::line_cnt_t  h_cnt;
	osd_pkg::line_cnt_t  width;
	osd_pkg::line_cnt_t  line_idx;
	osd_pkg::line_cnt_t  frame_lines;
	osd_pkg::line_cnt_t  v_start;
	osd_pkg::line_cnt_t  h_start_early;
	osd_pkg::line_cnt_t  osd_row;
	osd_pkg::line_cnt_t  osd_col;

	assign de_rise = de_in & ~de_d;
	assign de_fall = ~de_in & de_d;
	assign frame_start = de_rise && (gap_cnt > {width, 2'b00});

	// Centred on the previous frame's height
	assign v_start = ((frame_lines - osd_pkg::osd_height) >> 1) +
		osd_pkg::line_cnt_t'(osd_pkg::osd_y_offset);

	// Rows above the window wrap to large values
	assign osd_row = line_idx - v_start;
	assign row_ok = active && (osd_row < osd_pkg::osd_height);

	assign rd_addr = {osd_row[5:3], osd_col[7:0]};
	assign row_bit = osd_row[2:0];

	always_ff @(posedge clk_video) begin
		if (rst) begin
			de_d <= 1'b0;
			h_cnt <= '0;
			gap_cnt <= '0;
			width <= '0;
			line_idx <= '0;
			frame_lines <= '0;
			h_start_early <= '0;
			active <= 1'b0;
			osd_col <= '1;
			in_window <= 1'b0;
		end else begin
			de_d <= de_in;

			if (de_rise) begin
				h_cnt <= '0;
			end else if (h_cnt != '1) begin
				h_cnt <= h_cnt + 1'b1;
			end

			if (de_in) begin
				gap_cnt <= '0;
			end else if (gap_cnt != '1) begin
				gap_cnt <= gap_cnt + 1'b1;
			end

			if (de_fall) begin
				width <= h_cnt + 1'b1;
			end

			if (de_rise) begin
				// Two pixels early to cover the RAM and mixer stages
				h_start_early <= ((width - osd_pkg::osd_width) >> 1) +
					osd_pkg::line_cnt_t'(osd_pkg::osd_x_offset) - 12'd2;
				if (frame_start) begin
					line_idx <= '0;
					frame_lines <= line_idx + 1'b1;
					active <= osd_enable;
				end else if (line_idx != '1) begin
					line_idx <= line_idx + 1'b1;
				end
			end

			// Window column counter and flag
			if (h_cnt == h_start_early) begin
				osd_col <= '0;
				in_window <= row_ok;
			end else begin
				if (osd_col == osd_pkg::osd_width - 1'b1) begin
					in_window <= 1'b0;
				end
				if (osd_col != '1) begin
					osd_col <= osd_col + 1'b1;
				end
			end
		end
	end

endmodule

//--- osd_overlay.f
design/osd_pkg.sv
design/osd_cmd_decoder.sv
design/osd_bitmap_ram.sv
design/osd_raster_timer.sv
design/osd_mixer.sv
design/osd_overlay.sv
tests/osd_overlay_checker.sv
tests/osd_overlay_assertions.sv
tests/osd_overlay_tb.sv

//--- tests/osd_overlay_assertions.sv
////////////////////////////////////////////////////////////
// Bound into osd_overlay, checks pipeline delay and write address
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module osd_overlay_assertions (
	input logic                  clk_video,
	input logic                  rst,
	input logic                  de_in,
	input logic                  de_out,
	input logic                  wr_en,
	input osd_pkg::bitmap_addr_t wr_addr
);

	// Failures seen so far
	int fail_count = 0;

	// Data enable leaves exactly two cycles after it enters
	de_delay: assert property (@(posedge clk_video) disable iff (rst)
		de_out == $past(de_in, 2))
		else begin
			fail_count++;
			$error("de_out does not match de_in delayed by two cycles");
		end

	wr_addr_known: assert property (@(posedge clk_video) disable iff (rst)
		wr_en |-> !$isunknown(wr_addr))
		else begin
			fail_count++;
			$error("bitmap write address unknown during a write");
		end

endmodule

bind osd_overlay osd_overlay_assertions i_assertions (
	.clk_video (clk_video),
	.rst       (rst),
	.de_in     (de_in),
	.de_out    (de_out),
	.wr_en     (wr_en),
	.wr_addr   (wr_addr)
);

//--- tests/osd_overlay_checker.sv
////////////////////////////////////////////////////////////
// Samples on the falling edge, expects dout two cycles after din
// Window origin comes from the testbench table
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module osd_overlay_checker (
	input logic               clk_video,
	input logic               rst,
	input logic               cmd_sel,
	input logic               cmd_strobe,
	input osd_pkg::cmd_word_t cmd_din,
	input osd_pkg::rgb_t      din,
	input logic               de_in,
	input osd_pkg::rgb_t      dout,
	input logic               de_out,
	input osd_pkg::amix_t     amix,
	input logic               check_frame,
	input int                 x0,
	input int                 y0
);

	logic [7:0]  model_mem [0:2047];
	logic [10:0] model_addr;
	logic [7:0]  model_cmd;
	logic        model_en;
	logic        en_pend;
	logic [1:0]  model_amix;
	logic        sel_d;
	logic        strobe_d;
	logic        check_d;
	logic        de_d;
	logic        active;
	logic [23:0] exp_q [0:1];
	logic        exp_v [0:1];
	logic        de_q [0:1];
	int          word_idx;
	int          line;
	int          pix;
	int          err_dout;
	int          err_de;
	int          err_amix;

	function automatic logic [23:0] expected_pixel(input logic [23:0] px, input int ln,
		input int col_in);
		int          r;
		int          c;
		logic [10:0] a;
		logic        b;
		r = ln - y0;
		c = col_in - x0;
		if (!active || r < 0 || r >= 64 || c < 0 || c >= 256) begin
			return px;
		end
		a = 11'((r / 8) * 256 + c);
		b = model_mem[a][r % 8];
		// Red tint set, green and blue clear
		return {b, b, 1'b1, px[23:19], b, b, 1'b0, px[15:11], b, b, 1'b0, px[7:3]};
	endfunction

	always @(negedge clk_video) begin
		if (rst) begin
			model_addr = '0;
			model_cmd = '0;
			model_en = 1'b0;
			en_pend = 1'b0;
			model_amix = 2'd0;
			sel_d = 1'b0;
			strobe_d = 1'b0;
			check_d = 1'b0;
			de_d = 1'b0;
			active = 1'b0;
			word_idx = 0;
			line = 0;
			pix = 0;
			for (int i = 0; i < 2; i++) begin
				exp_q[i] = '0;
				exp_v[i] = 1'b0;
				de_q[i] = 1'b0;
			end
		end else begin
			if (de_out !== de_q[1]) begin
				err_de++;
				$display("** Error at %0t: de_out expected %b, got %b", $time, de_q[1], de_out);
			end
			if (exp_v[1] && dout !== exp_q[1]) begin
				err_dout++;
				if (err_dout <= 20) begin
					$display("** Error at %0t: dout expected %h, got %h", $time, exp_q[1], dout);
				end
			end
			if (!cmd_sel && amix !== model_amix) begin
				err_amix++;
				if (err_amix <= 20) begin
					$display("** Error at %0t: amix expected %0d, got %0d", $time, model_amix,
						amix);
				end
			end
			de_q[1] = de_q[0];
			exp_v[1] = exp_v[0];
			exp_q[1] = exp_q[0];

			// Pixel position within the checked frame
			if (check_frame && !check_d) begin
				line = -1;
				active = model_en;
			end
			if (de_in && !de_d) begin
				line++;
				pix = 0;
			end
			de_q[0] = de_in;
			exp_v[0] = check_frame && de_in;
			exp_q[0] = expected_pixel(din, line, pix);
			if (de_in) begin
				pix++;
			end
			check_d = check_frame;
			de_d = de_in;

			// Command words
			if (!cmd_sel) begin
				if (sel_d && word_idx > 0 && model_cmd == osd_pkg::cmd_enable) begin
					model_en = en_pend;
				end
				word_idx = 0;
			end else if (cmd_strobe && !strobe_d) begin
				if (word_idx == 0) begin
					model_cmd = cmd_din[7:0];
				end else if (model_cmd == osd_pkg::cmd_write) begin
					if (word_idx == 4) begin
						model_addr = {cmd_din[2:0], 8'h00};
					end else if (word_idx > 4) begin
						model_mem[model_addr] = cmd_din[7:0];
						model_addr = model_addr + 11'd1;
					end
				end else if (model_cmd == osd_pkg::cmd_enable && word_idx == 1) begin
					en_pend = cmd_din[0];
				end else if (model_cmd == osd_pkg::cmd_amix) begin
					model_amix = cmd_din[1:0];
				end
				word_idx++;
			end
			sel_d = cmd_sel;
			strobe_d = cmd_strobe;
		end
	end

	initial begin
		err_dout = 0;
		err_de = 0;
		err_amix = 0;
	end

endmodule

//--- tests/osd_overlay_tb.sv
////////////////////////////////////////////////////////////
// Runs each table row for three frames, only the third is compared
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module osd_overlay_tb;

	localparam int num_tests = 5;
	localparam int hblank = 40;
	localparam int vblank_widths = 6;
	localparam int reset_cycles = 16;
	localparam int kind_blank = 0;
	localparam int kind_random = 1;
	localparam int kind_stripes = 2;

	// Width, lines, expected window origin, fill, enable, amix
	int t_width [num_tests] = '{320, 320, 320, 400, 400};
	int t_lines [num_tests] = '{240, 240, 240, 300, 300};
	int t_x0 [num_tests] = '{32, 32, 32, 72, 72};
	int t_y0 [num_tests] = '{88, 88, 88, 118, 118};
	int t_kind [num_tests] = '{kind_blank, kind_random, kind_stripes, kind_random, kind_blank};
	int t_band [num_tests] = '{0, 0, 5, 2, 0};
	int t_bytes [num_tests] = '{0, 2048, 256, 256, 0};
	int t_enable [num_tests] = '{0, 1, 1, 1, 0};
	int t_amix [num_tests] = '{0, 2, 1, 3, 3};

	logic               clk_video;
	logic               rst;
	logic               cmd_sel;
	logic               cmd_strobe;
	osd_pkg::cmd_word_t cmd_din;
	osd_pkg::rgb_t      din;
	logic               de_in;
	osd_pkg::rgb_t      dout;
	logic               de_out;
	osd_pkg::amix_t     amix;
	logic               check_frame;
	int                 cur_x0;
	int                 cur_y0;
	int                 prev_errs;
	int                 errs;

	osd_overlay i_osd_overlay (
		.clk_video  (clk_video),
		.rst        (rst),
		.cmd_sel    (cmd_sel),
		.cmd_strobe (cmd_strobe),
		.cmd_din    (cmd_din),
		.din        (din),
		.de_in      (de_in),
		.dout       (dout),
		.de_out     (de_out),
		.amix       (amix)
	);

	osd_overlay_checker i_checker (
		.clk_video   (clk_video),
		.rst         (rst),
		.cmd_sel     (cmd_sel),
		.cmd_strobe  (cmd_strobe),
		.cmd_din     (cmd_din),
		.din         (din),
		.de_in       (de_in),
		.dout        (dout),
		.de_out      (de_out),
		.amix        (amix),
		.check_frame (check_frame),
		.x0          (cur_x0),
		.y0          (cur_y0)
	);

	initial begin
		clk_video = 1'b0;
		forever #10 clk_video = ~clk_video;
	end

	function automatic longint watchdog_cycles();
		longint total;
		total = 0;
		for (int i = 0; i < num_tests; i++) begin
			total += 3 * ((t_width[i] + hblank) * t_lines[i] + vblank_widths * t_width[i]);
		end
		return total * 2 + reset_cycles;
	endfunction

	function automatic logic [7:0] pattern_byte(input int kind, input logic [10:0] a);
		if (kind == kind_random) begin
			return 8'($urandom);
		end
		if (kind == kind_stripes) begin
			return (a[2] ? 8'hCC : 8'h33) ^ a[7:0] ^ {5'd0, a[10:8]};
		end
		return 8'h00;
	endfunction

	task automatic next_cycle();
		@(posedge clk_video);
		#2;
	endtask

	task automatic send_word(input logic [15:0] w);
		cmd_din = w;
		cmd_strobe = 1'b1;
		next_cycle();
		cmd_strobe = 1'b0;
		next_cycle();
	endtask

	task automatic end_transaction();
		cmd_sel = 1'b0;
		next_cycle();
		next_cycle();
	endtask

	task automatic send_commands(input int i);
		cmd_sel = 1'b1;
		next_cycle();
		send_word({8'h00, osd_pkg::cmd_enable});
		send_word(16'(t_enable[i]));
		end_transaction();
		cmd_sel = 1'b1;
		next_cycle();
		send_word({8'h00, osd_pkg::cmd_amix});
		send_word(16'(t_amix[i]));
		end_transaction();
		if (t_bytes[i] > 0) begin
			cmd_sel = 1'b1;
			next_cycle();
			send_word({8'h00, osd_pkg::cmd_write});
			send_word(16'h0000);
			send_word(16'h0000);
			send_word(16'h0000);
			send_word(16'(t_band[i]));
			for (int k = 0; k < t_bytes[i]; k++) begin
				send_word({8'h00, pattern_byte(t_kind[i], 11'(t_band[i] * 256 + k))});
			end
			end_transaction();
		end
	endtask

	task automatic send_frames(input int i);
		for (int f = 0; f < 3; f++) begin
			check_frame = (f == 2);
			for (int l = 0; l < t_lines[i]; l++) begin
				de_in = 1'b1;
				for (int p = 0; p < t_width[i]; p++) begin
					din = 24'($urandom);
					next_cycle();
				end
				de_in = 1'b0;
				din = '0;
				repeat (hblank) next_cycle();
			end
			repeat (vblank_widths * t_width[i]) next_cycle();
		end
		check_frame = 1'b0;
	endtask

	// Watchdog
	initial begin
		#(watchdog_cycles() * 20);
		$display("Watchdog timeout: the run did not finish in time");
		$display("Errors found");
		$finish;
	end

	initial begin
		void'($urandom(97));
		rst = 1'b1;
		cmd_sel = 1'b0;
		cmd_strobe = 1'b0;
		cmd_din = '0;
		din = '0;
		de_in = 1'b0;
		check_frame = 1'b0;
		cur_x0 = 0;
		cur_y0 = 0;
		prev_errs = 0;
		errs = 0;
		repeat (reset_cycles) @(posedge clk_video);
		#2;
		rst = 1'b0;
		repeat (4) next_cycle();

		for (int i = 0; i < num_tests; i++) begin
			cur_x0 = t_x0[i];
			cur_y0 = t_y0[i];
			send_commands(i);
			send_frames(i);
			errs = i_checker.err_dout + i_checker.err_de + i_checker.err_amix +
				i_osd_overlay.i_assertions.fail_count;
			$display("test %0d: %0dx%0d enable %0d amix %0d, %0d errors", i, t_width[i],
				t_lines[i], t_enable[i], t_amix[i], errs - prev_errs);
			prev_errs = errs;
		end

		$display("%0d tests, dout errors %0d, de_out errors %0d, amix errors %0d, %s %0d",
			num_tests, i_checker.err_dout, i_checker.err_de, i_checker.err_amix,
			"assertion failures", i_osd_overlay.i_assertions.fail_count);
		if (errs == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule
